// File: cpu_pkg.sv
package cpu_pkg;

  typedef logic [31:0] word_t;

  typedef enum logic [5:0] {
    op_add  = 6'h00,
    op_sub  = 6'h01,
    op_and  = 6'h02,
    op_or   = 6'h03,
    op_xor  = 6'h04,
    op_shl  = 6'h05,
    op_shr  = 6'h06,
    op_addi = 6'h10,
    op_ldi  = 6'h11, // zero-extended immediate
    op_ldw  = 6'h12,
    op_ldb  = 6'h13,
    op_stw  = 6'h14,
    op_stb  = 6'h15,
    op_beq  = 6'h16,
    op_bne  = 6'h17,
    op_halt = 6'h3f
  } op_e;

  // same word seen as register form and immediate form
  typedef union packed {
    struct packed {
      op_e         op;
      logic [3:0]  rd;
      logic [3:0]  ra;
      logic [3:0]  rb;
      logic [13:0] unused;
    } r;
    struct packed {
      op_e         op;
      logic [3:0]  rd;
      logic [3:0]  ra;
      logic [15:0] imm;
      logic [1:0]  unused;
    } i;
  } instr_u;

  typedef enum logic [2:0] {
    alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_shl, alu_shr
  } alu_func_e;

  typedef enum logic [1:0] {pcsel_hold, pcsel_next, pcsel_rel} pcsel_e;
  typedef enum logic [1:0] {marsel_hold, marsel_alu} marsel_e;
  typedef enum logic [1:0] {mdrsel_hold, mdrsel_bus, mdrsel_b} mdrsel_e;
  typedef enum logic [1:0] {regsel_alu, regsel_mdr, regsel_uval} regsel_e;
  typedef enum logic {alu2sel_b, alu2sel_sval} alu2sel_e;
  typedef enum logic {addrsel_pc, addrsel_mar} addrsel_e;

  typedef enum logic [3:0] {
    st_reset, st_fetch, st_decode, st_exec, st_mem, st_wb, st_halt
  } state_e;

  typedef logic [2:0] ccr_t; // carry, less-than, zero
  localparam int ccr_c  = 2;
  localparam int ccr_lt = 1;
  localparam int ccr_z  = 0;

  localparam word_t reset_pc = 32'h0000_0000;

  // wishbone lane selects
  localparam logic [3:0] sel_word  = 4'b1111;
  localparam logic [3:0] sel_byte0 = 4'b0001;

endpackage

// File: cpu_alu.sv
`timescale 1ns/10ps

module cpu_alu (
  input  cpu_pkg::word_t     in1_i,
  input  cpu_pkg::word_t     in2_i,
  input  cpu_pkg::alu_func_e func_i,
  output cpu_pkg::word_t     out_o,
  output logic               c_o,
  output logic               n_o,
  output logic               v_o,
  output logic               z_o
);
  import cpu_pkg::*;

  logic [32:0] sum;

  always_comb begin
    sum = '0;
    v_o = 1'b0;
    case (func_i)
      alu_add: begin
        sum = {1'b0, in1_i} + {1'b0, in2_i};
        v_o = (in1_i[31] == in2_i[31]) && (sum[31] != in1_i[31]);
      end
      alu_sub: begin
        sum = {1'b0, in1_i} - {1'b0, in2_i}; // carry is borrow
        v_o = (in1_i[31] != in2_i[31]) && (sum[31] != in1_i[31]);
      end
      alu_and: sum = {1'b0, in1_i & in2_i};
      alu_or:  sum = {1'b0, in1_i | in2_i};
      alu_xor: sum = {1'b0, in1_i ^ in2_i};
      alu_shl: sum = {1'b0, in1_i << in2_i[4:0]};
      alu_shr: sum = {1'b0, in1_i >> in2_i[4:0]}; // logical
      default: sum = '0;
    endcase
    out_o = sum[31:0];
    c_o   = sum[32];
    n_o   = sum[31];
    z_o   = (sum[31:0] == 32'h0);
  end

endmodule

// File: cpu_regfile.sv
`timescale 1ns/10ps

module cpu_regfile (
  input  logic           clk_i,
  input  logic           rst_i,
  input  logic [3:0]     read1_i,
  input  logic [3:0]     read2_i,
  input  logic [3:0]     write_addr_i,
  input  cpu_pkg::word_t write_data_i,
  input  logic           write_en_i,
  output cpu_pkg::word_t data1_o,
  output cpu_pkg::word_t data2_o
);
  import cpu_pkg::*;

  word_t regs [16];

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      for (int i = 0; i < 16; i++) regs[i] <= '0;
    end else if (write_en_i && (write_addr_i != 4'd0)) begin
      regs[write_addr_i] <= write_data_i;
    end
  end

  // r0 is hardwired zero
  assign data1_o = (read1_i == 4'd0) ? '0 : regs[read1_i];
  assign data2_o = (read2_i == 4'd0) ? '0 : regs[read2_i];

endmodule

// File: cpu_bus_lanes.sv
`timescale 1ns/10ps

module cpu_bus_lanes (
  input  logic [3:0]     sel_i,
  input  cpu_pkg::word_t dat_i,
  input  cpu_pkg::word_t cpu_i,
  output cpu_pkg::word_t dat_o,
  output cpu_pkg::word_t cpu_o
);
  import cpu_pkg::*;

  // store side, byte copied to every lane so sel_o picks it
  assign dat_o = (sel_i == sel_word) ? cpu_i : {4{cpu_i[7:0]}};

  // load side
  always_comb begin
    case (sel_i)
      sel_byte0:      cpu_o = {24'h0, dat_i[7:0]};
      sel_byte0 << 1: cpu_o = {24'h0, dat_i[15:8]};
      sel_byte0 << 2: cpu_o = {24'h0, dat_i[23:16]};
      sel_byte0 << 3: cpu_o = {24'h0, dat_i[31:24]};
      default:        cpu_o = dat_i; // full word
    endcase
  end

endmodule

// File: cpu_datapath.sv
`timescale 1ns/10ps

module cpu_datapath (
  input  logic               clk_i,
  input  logic               rst_i,
  input  cpu_pkg::pcsel_e    pcsel_i,
  input  cpu_pkg::marsel_e   marsel_i,
  input  cpu_pkg::mdrsel_e   mdrsel_i,
  input  cpu_pkg::regsel_e   regsel_i,
  input  cpu_pkg::alu2sel_e  alu2sel_i,
  input  cpu_pkg::addrsel_e  addrsel_i,
  input  cpu_pkg::alu_func_e alu_func_i,
  input  logic               ir_write_i,
  input  logic               a_write_i,
  input  logic               b_write_i,
  input  logic               ccr_write_i,
  input  logic [3:0]         reg_read1_i,
  input  logic [3:0]         reg_read2_i,
  input  logic [3:0]         reg_write_addr_i,
  input  logic               reg_write_i,
  input  cpu_pkg::word_t     dat_i,
  input  logic [3:0]         sel_i,
  output cpu_pkg::word_t     adr_o,
  output cpu_pkg::word_t     dat_o,
  output cpu_pkg::instr_u    ir_o,
  output cpu_pkg::ccr_t      ccr_o
);
  import cpu_pkg::*;

  // special registers
  word_t  pc, mar, mdr, a, b;
  instr_u ir;
  ccr_t   ccr;

  word_t pc_nxt, mar_nxt, mdr_nxt, alu_in2, reg_data_in;
  word_t alu_out, reg_data1, reg_data2, load_data;
  word_t ir_sval, ir_uval;
  logic  alu_c, alu_n, alu_v, alu_z;

  assign ir_sval = {{16{ir.i.imm[15]}}, ir.i.imm};
  assign ir_uval = {16'h0, ir.i.imm};

  assign adr_o = (addrsel_i == addrsel_mar) ? mar : pc;
  assign ir_o  = ir;
  assign ccr_o = ccr;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      pc  <= reset_pc;
      ir  <= '0;
      ccr <= '0;
    end else begin
      pc <= pc_nxt;
      if (ir_write_i) ir <= dat_i;
      if (ccr_write_i) ccr <= {alu_c, alu_n ^ alu_v, alu_z};
    end
  end

  always_ff @(posedge clk_i) begin
    mar <= mar_nxt;
    mdr <= mdr_nxt;
    if (a_write_i) a <= reg_data1;
    if (b_write_i) b <= reg_data2;
  end

  always_comb begin
    case (pcsel_i)
      pcsel_next: pc_nxt = pc + 32'd4;
      pcsel_rel:  pc_nxt = pc + {ir_sval[29:0], 2'b00};
      default:    pc_nxt = pc;
    endcase
    case (marsel_i)
      marsel_alu: mar_nxt = alu_out;
      default:    mar_nxt = mar;
    endcase
    case (mdrsel_i)
      mdrsel_bus: mdr_nxt = load_data; // already lane aligned
      mdrsel_b:   mdr_nxt = b;
      default:    mdr_nxt = mdr;
    endcase
    case (regsel_i)
      regsel_mdr:  reg_data_in = mdr;
      regsel_uval: reg_data_in = ir_uval;
      default:     reg_data_in = alu_out;
    endcase
    alu_in2 = (alu2sel_i == alu2sel_sval) ? ir_sval : b;
  end

  cpu_alu alu0 (
    .in1_i  (a),
    .in2_i  (alu_in2),
    .func_i (alu_func_i),
    .out_o  (alu_out),
    .c_o    (alu_c),
    .n_o    (alu_n),
    .v_o    (alu_v),
    .z_o    (alu_z)
  );

  cpu_regfile reg0 (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .read1_i      (reg_read1_i),
    .read2_i      (reg_read2_i),
    .write_addr_i (reg_write_addr_i),
    .write_data_i (reg_data_in),
    .write_en_i   (reg_write_i),
    .data1_o      (reg_data1),
    .data2_o      (reg_data2)
  );

  cpu_bus_lanes bus0 (
    .sel_i (sel_i),
    .dat_i (dat_i),
    .cpu_i (mdr),
    .dat_o (dat_o),
    .cpu_o (load_data)
  );

endmodule

// File: cpu_control.sv
`timescale 1ns/10ps

module cpu_control (
  input  logic               clk_i,
  input  logic               rst_i,
  input  cpu_pkg::instr_u    ir_i,
  input  cpu_pkg::ccr_t      ccr_i,
  input  logic               ack_i,
  input  logic [1:0]         adr_low_i,
  output cpu_pkg::pcsel_e    pcsel_o,
  output cpu_pkg::marsel_e   marsel_o,
  output cpu_pkg::mdrsel_e   mdrsel_o,
  output cpu_pkg::regsel_e   regsel_o,
  output cpu_pkg::alu2sel_e  alu2sel_o,
  output cpu_pkg::addrsel_e  addrsel_o,
  output cpu_pkg::alu_func_e alu_func_o,
  output logic [3:0]         reg_read1_o,
  output logic [3:0]         reg_read2_o,
  output logic [3:0]         reg_write_addr_o,
  output logic               reg_write_o,
  output logic               ir_write_o,
  output logic               a_write_o,
  output logic               b_write_o,
  output logic               ccr_write_o,
  output logic [3:0]         sel_o,
  output logic               cyc_o,
  output logic               stb_o,
  output logic               we_o,
  output logic               halt_o
);
  import cpu_pkg::*;

  state_e state, state_nxt;
  op_e    op;
  logic   is_rform, is_load, is_store, is_byte, is_branch;
  logic   writes_reg, take_branch, bus_state;

  assign op          = ir_i.r.op;
  assign is_rform    = op inside {op_add, op_sub, op_and, op_or, op_xor, op_shl, op_shr};
  assign is_load     = op inside {op_ldw, op_ldb};
  assign is_store    = op inside {op_stw, op_stb};
  assign is_byte     = op inside {op_ldb, op_stb};
  assign is_branch   = op inside {op_beq, op_bne};
  assign writes_reg  = is_rform || is_load || (op == op_addi) || (op == op_ldi);
  assign take_branch = (op == op_beq) ? ccr_i[ccr_z] : !ccr_i[ccr_z];

  // ra always on port 1, port 2 gets rb or the rd of a store / branch
  assign reg_read1_o      = ir_i.i.ra;
  assign reg_read2_o      = is_rform ? ir_i.r.rb : ir_i.i.rd;
  assign reg_write_addr_o = ir_i.i.rd;

  assign bus_state = (state == st_fetch) || (state == st_mem);
  assign cyc_o     = bus_state;
  assign stb_o     = bus_state;
  assign we_o      = (state == st_mem) && is_store;
  assign halt_o    = (state == st_halt);
  assign addrsel_o = (state == st_mem) ? addrsel_mar : addrsel_pc;
  assign alu2sel_o = (is_rform || is_branch) ? alu2sel_b : alu2sel_sval;
  assign sel_o     = ((state == st_mem) && is_byte) ? (sel_byte0 << adr_low_i) : sel_word;

  always_comb begin
    case (op)
      op_sub, op_beq, op_bne: alu_func_o = alu_sub;
      op_and:  alu_func_o = alu_and;
      op_or:   alu_func_o = alu_or;
      op_xor:  alu_func_o = alu_xor;
      op_shl:  alu_func_o = alu_shl;
      op_shr:  alu_func_o = alu_shr;
      default: alu_func_o = alu_add; // addi and address calc too
    endcase
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) state <= st_reset;
    else       state <= state_nxt;
  end

  always_comb begin
    state_nxt   = state;
    pcsel_o     = pcsel_hold;
    marsel_o    = marsel_hold;
    mdrsel_o    = mdrsel_hold;
    regsel_o    = regsel_alu;
    ir_write_o  = 1'b0;
    a_write_o   = 1'b0;
    b_write_o   = 1'b0;
    ccr_write_o = 1'b0;
    reg_write_o = 1'b0;
    case (state)
      st_reset: state_nxt = st_fetch;
      st_fetch: begin
        if (ack_i) begin
          ir_write_o = 1'b1;
          state_nxt  = st_decode;
        end
      end
      st_decode: begin
        a_write_o = 1'b1;
        b_write_o = 1'b1;
        state_nxt = (op == op_halt) ? st_halt : st_exec;
      end
      st_exec: begin
        ccr_write_o = is_rform || is_branch || (op == op_addi);
        if (is_load || is_store) begin
          marsel_o = marsel_alu;
          if (is_store) mdrsel_o = mdrsel_b;
          state_nxt = st_mem;
        end else begin
          state_nxt = st_wb;
        end
      end
      st_mem: begin
        if (ack_i) begin // stay here while the slave stalls
          if (is_load) mdrsel_o = mdrsel_bus;
          state_nxt = st_wb;
        end
      end
      st_wb: begin
        if (is_branch && take_branch) pcsel_o = pcsel_rel;
        else                          pcsel_o = pcsel_next;
        if (is_load)               regsel_o = regsel_mdr;
        else if (op == op_ldi)     regsel_o = regsel_uval;
        reg_write_o = writes_reg;
        state_nxt   = st_fetch;
      end
      st_halt: state_nxt = st_halt; // only reset leaves
      default: state_nxt = st_reset;
    endcase
  end

endmodule

// File: cpu_top.sv
`timescale 1ns/10ps

module cpu_top (
  input  logic           clk_i,
  input  logic           rst_i,
  input  logic           ack_i,
  input  cpu_pkg::word_t dat_i,
  output cpu_pkg::word_t adr_o,
  output cpu_pkg::word_t dat_o,
  output logic [3:0]     sel_o,
  output logic           cyc_o,
  output logic           stb_o,
  output logic           we_o,
  output logic           halt_o
);
  import cpu_pkg::*;

  pcsel_e    pcsel;
  marsel_e   marsel;
  mdrsel_e   mdrsel;
  regsel_e   regsel;
  alu2sel_e  alu2sel;
  addrsel_e  addrsel;
  alu_func_e alu_func;
  instr_u    ir;
  ccr_t      ccr;
  logic [3:0] reg_read1, reg_read2, reg_write_addr;
  logic       reg_write, ir_write, a_write, b_write, ccr_write;

  cpu_datapath dp0 (
    .clk_i (clk_i), .rst_i (rst_i),
    .pcsel_i (pcsel), .marsel_i (marsel), .mdrsel_i (mdrsel),
    .regsel_i (regsel), .alu2sel_i (alu2sel), .addrsel_i (addrsel),
    .alu_func_i (alu_func), .ir_write_i (ir_write), .a_write_i (a_write),
    .b_write_i (b_write), .ccr_write_i (ccr_write),
    .reg_read1_i (reg_read1), .reg_read2_i (reg_read2),
    .reg_write_addr_i (reg_write_addr), .reg_write_i (reg_write),
    .dat_i (dat_i), .sel_i (sel_o),
    .adr_o (adr_o), .dat_o (dat_o), .ir_o (ir), .ccr_o (ccr)
  );

  cpu_control con0 (
    .clk_i (clk_i), .rst_i (rst_i), .ir_i (ir), .ccr_i (ccr),
    .ack_i (ack_i), .adr_low_i (adr_o[1:0]),
    .pcsel_o (pcsel), .marsel_o (marsel), .mdrsel_o (mdrsel),
    .regsel_o (regsel), .alu2sel_o (alu2sel), .addrsel_o (addrsel),
    .alu_func_o (alu_func), .reg_read1_o (reg_read1), .reg_read2_o (reg_read2),
    .reg_write_addr_o (reg_write_addr), .reg_write_o (reg_write),
    .ir_write_o (ir_write), .a_write_o (a_write), .b_write_o (b_write),
    .ccr_write_o (ccr_write), .sel_o (sel_o), .cyc_o (cyc_o),
    .stb_o (stb_o), .we_o (we_o), .halt_o (halt_o)
  );

endmodule

// File: tb_cpu.sv
`timescale 1ns/10ps

module tb_cpu;
  import cpu_pkg::*;

  logic       clk_i;
  logic       rst_i;
  logic       ack_i;
  word_t      dat_i;
  word_t      adr_o;
  word_t      dat_o;
  logic [3:0] sel_o;
  logic       cyc_o;
  logic       stb_o;
  logic       we_o;
  logic       halt_o;

  word_t       mem [256];
  logic [7:0]  prog_addr [$]; // word index
  word_t       prog_data [$];
  word_t       exp_adr [$];
  logic [3:0]  exp_sel [$];
  word_t       exp_dat [$];
  string       case_name;
  string       run_name;
  int          store_count;
  int          max_wait;
  int          wait_left;
  logic        in_cycle;
  logic [31:0] rng;

  cpu_top dut0 (
    .clk_i  (clk_i),
    .rst_i  (rst_i),
    .ack_i  (ack_i),
    .dat_i  (dat_i),
    .adr_o  (adr_o),
    .dat_o  (dat_o),
    .sel_o  (sel_o),
    .cyc_o  (cyc_o),
    .stb_o  (stb_o),
    .we_o   (we_o),
    .halt_o (halt_o)
  );

  always #4 clk_i = ~clk_i;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // drop newline and trailing blanks
  function automatic string trim_line(input string s);
    string t;
    t = s;
    while (t.len() > 0 && (t.getc(t.len() - 1) == 8'h0a || t.getc(t.len() - 1) == 8'h0d ||
                           t.getc(t.len() - 1) == 8'h20))
      t = t.substr(0, t.len() - 2);
    return t;
  endfunction

  task automatic stop_with_error(input string what);
    $display("%s", what);
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check_word(input string what, input word_t exp, input word_t act);
    if (exp !== act)
      stop_with_error($sformatf("CHECK FAILED %s %s: expected %08h, actual %08h",
                                run_name, what, exp, act));
  endtask

  task automatic check_sel(input string what, input logic [3:0] exp, input logic [3:0] act);
    if (exp !== act)
      stop_with_error($sformatf("CHECK FAILED %s %s: expected %04b, actual %04b",
                                run_name, what, exp, act));
  endtask

  task automatic take_store(input logic [7:0] idx);
    string tag;
    int    b;
    if (store_count >= exp_adr.size()) begin
      stop_with_error($sformatf("%s: store of %08h to %08h was not expected",
                                run_name, dat_o, adr_o));
    end else begin
      tag = $sformatf("store %0d", store_count);
      check_word({tag, " address"}, exp_adr[store_count], adr_o);
      check_sel({tag, " sel"}, exp_sel[store_count], sel_o);
      check_word({tag, " data"}, exp_dat[store_count], dat_o);
      for (b = 0; b < 4; b++)
        if (sel_o[b]) mem[idx][8*b +: 8] = dat_o[8*b +: 8];
      store_count++;
    end
  endtask

  // wishbone slave, one call per cycle just after the rising edge
  task automatic bus_step;
    logic [7:0] idx;
    idx = adr_o[9:2];
    if (ack_i) begin
      ack_i = 1'b0; // taken by the master at this edge
      dat_i = '0;
    end else if (cyc_o && stb_o) begin
      if (!in_cycle) begin
        in_cycle  = 1'b1;
        rng       = xorshift32(rng);
        wait_left = int'(rng % 32'(max_wait + 1));
      end
      if (wait_left > 0) begin
        wait_left--;
      end else begin
        in_cycle = 1'b0;
        ack_i    = 1'b1;
        if (we_o) take_store(idx);
        else      dat_i = mem[idx];
      end
    end
  endtask

  task automatic run_case(input int wait_max);
    int limit;
    int cycles;
    int i;
    run_name  = $sformatf("%s/wait%0d", case_name, wait_max);
    max_wait  = wait_max;
    limit     = 6 * (wait_max + 2) * prog_data.size();
    for (i = 0; i < 256; i++)
      mem[i[7:0]] = {i[7:0], ~i[7:0], i[7:0], ~i[7:0]};
    for (i = 0; i < prog_data.size(); i++)
      mem[prog_addr[i]] = prog_data[i];
    store_count = 0;
    in_cycle    = 1'b0;
    ack_i       = 1'b0;
    dat_i       = '0;
    rst_i       = 1'b1;
    repeat (2) @(posedge clk_i);
    #1 rst_i = 1'b0;
    if (cyc_o || stb_o || we_o || halt_o)
      stop_with_error($sformatf("%s: bus or halt active straight after reset", run_name));
    cycles = 0;
    while (!halt_o) begin
      @(posedge clk_i);
      #1;
      bus_step();
      cycles++;
      if (cycles > limit)
        stop_with_error($sformatf("%s: no halt within %0d cycles", run_name, limit));
    end
    if (store_count != exp_adr.size())
      stop_with_error($sformatf("%s: halted after %0d of %0d expected stores",
                                run_name, store_count, exp_adr.size()));
    repeat (20) begin
      @(posedge clk_i);
      #1;
      if (!halt_o)
        stop_with_error($sformatf("%s: halt_o dropped after halt", run_name));
      if (cyc_o || stb_o)
        stop_with_error($sformatf("%s: bus cycle started after halt", run_name));
    end
  endtask

  initial begin
    int          fd;
    int          n;
    int          cases_run;
    int          file_wait;
    string       line;
    string       rest;
    logic [7:0]  tag;
    logic [31:0] v1, v2, v3;
    clk_i     = 1'b0;
    rst_i     = 1'b1;
    ack_i     = 1'b0;
    dat_i     = '0;
    rng       = 32'd1;
    cases_run = 0;
    file_wait = 0;
    max_wait  = 0;
    case_name = "unnamed";
    fd = $fopen("cpu_cases.txt", "r");
    if (fd == 0) stop_with_error("cannot open cpu_cases.txt");
    while (!$feof(fd)) begin
      n = $fgets(line, fd);
      if (n > 0 && line.len() > 0) begin
        tag  = line.getc(0);
        rest = (line.len() > 1) ? line.substr(1, line.len() - 1) : "";
        case (tag)
          "N": begin
            case_name = trim_line(line.substr(2, line.len() - 1));
            prog_addr.delete();
            prog_data.delete();
            exp_adr.delete();
            exp_sel.delete();
            exp_dat.delete();
          end
          "P": begin
            if ($sscanf(rest, "%h %h", v1, v2) != 2)
              stop_with_error({"bad program line in cpu_cases.txt: ", trim_line(line)});
            prog_addr.push_back(v1[7:0]);
            prog_data.push_back(v2);
          end
          "S": begin
            if ($sscanf(rest, "%h %b %h", v1, v2, v3) != 3)
              stop_with_error({"bad store line in cpu_cases.txt: ", trim_line(line)});
            exp_adr.push_back(v1);
            exp_sel.push_back(v2[3:0]);
            exp_dat.push_back(v3);
          end
          "W": begin
            if ($sscanf(rest, "%d", v1) != 1)
              stop_with_error({"bad wait line in cpu_cases.txt: ", trim_line(line)});
            file_wait = int'(v1);
          end
          "E": begin
            run_case(0); // no wait states first
            run_case(file_wait);
            cases_run++;
            $display("case %s done", case_name);
          end
          "#", 8'h0a, 8'h0d: ;
          default: stop_with_error({"unknown line in cpu_cases.txt: ", trim_line(line)});
        endcase
      end
    end
    $fclose(fd);
    if (cases_run == 0) begin
      stop_with_error("no complete case found in cpu_cases.txt");
    end else begin
      $display("*** TEST PASSED ***");
      $finish;
    end
  end

endmodule

// File: cpu_cases.txt
# N name | P word_index data | S byte_addr sel(binary) data | W max_wait | E end of case
# numbers in hex except sel and W, each case runs at wait 0 and then at wait W
N alu_ops
P 00 444048D0
P 01 448003C0
P 02 45000010
P 03 00C48000
P 04 50C00800
P 05 04C84000
P 06 50C00810
P 07 08C48000
P 08 50C00820
P 09 0CC48000
P 0A 50C00830
P 0B 10C48000
P 0C 50C00840
P 0D 14C50000
P 0E 50C00850
P 0F 18C50000
P 10 50C00860
P 11 4147FFFC
P 12 51400870
P 13 FC000000
S 200 1111 00001324
S 204 1111 FFFFEEBC
S 208 1111 00000030
S 20C 1111 000012F4
S 210 1111 000012C4
S 214 1111 00012340
S 218 1111 00000123
S 21C 1111 00001233
W 5
E
# stb on each lane, ldw back, then ldb of every lane of a data word
N byte_lanes
P 00 44400294
P 01 54400C00
P 02 448000F0
P 03 54800C04
P 04 44C001F8
P 05 54C00C08
P 06 4500070C
P 07 55000C0C
P 08 49400C00
P 09 51400C10
P 0A 4D800D00
P 0B 51800C20
P 0C 4D800D04
P 0D 51800C30
P 0E 4D800D08
P 0F 51800C40
P 10 4D800D0C
P 11 51800C50
P 12 FC000000
P D0 89ABCDEF
S 300 0001 A5A5A5A5
S 301 0010 3C3C3C3C
S 302 0100 7E7E7E7E
S 303 1000 C3C3C3C3
S 304 1111 C37E3CA5
S 308 1111 000000EF
S 30C 1111 000000CD
S 310 1111 000000AB
S 314 1111 00000089
W 5
E
# stores at 0x380 and 0x390 sit on skipped paths
N branches
P 00 44400014
P 01 44800014
P 02 44C0001C
P 03 58480008
P 04 50C00E00
P 05 50400E10
P 06 5C480008
P 07 50C00E20
P 08 584C0008
P 09 50800E30
P 0A 5C4C0008
P 0B 50C00E40
P 0C 50C00E50
P 0D FC000000
S 384 1111 00000005
S 388 1111 00000007
S 38C 1111 00000005
S 394 1111 00000007
W 5
E

// File: vlog.f
cpu_pkg.sv
cpu_alu.sv
cpu_regfile.sv
cpu_bus_lanes.sv
cpu_datapath.sv
cpu_control.sv
cpu_top.sv
tb_cpu.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module tb_cpu -f vlog.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vtb_cpu)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qF '*** TEST PASSED ***'; then
  exit 0
fi
exit 1
